/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int XLEN = 32;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // forwarding source select
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_MEM = 2'd1;
    localparam logic [1:0] FWD_WB = 2'd2;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOpE;

    typedef struct packed {
        aluOpE aluOp;
        logic  srcImm;   // operand b from immediate
        logic  regWe;
        logic  memRd;
        logic  memWr;
        logic  dstRt;    // write rt, not rd
        logic  isBranch;
    } ctrlT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT            ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rsVal;
        logic [XLEN-1:0] rtVal;
        logic [XLEN-1:0] imm;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      rd;
    } idExT;

    typedef struct packed {
        ctrlT            ctrl;
        logic [XLEN-1:0] aluOut;
        logic [XLEN-1:0] storeData;
        logic [4:0]      dst;
    } exMemT;

    typedef struct packed {
        logic            regWe;
        logic            memRd;
        logic [XLEN-1:0] aluOut;
        logic [XLEN-1:0] loadData;
        logic [4:0]      dst;
    } memWbT;

endpackage

`default_nettype wire

/* rtl/fwdIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface fwdIf;

    logic [4:0] exRs;      // operands of the instruction in EX
    logic [4:0] exRt;
    logic       exMemRd;   // EX holds a load
    logic [4:0] idRs;      // sources read in ID
    logic [4:0] idRt;
    logic [4:0] memDst;
    logic       memWe;
    logic [4:0] wbDst;
    logic       wbWe;
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    logic       stall;

    modport hazard (
        input  exRs, exRt, exMemRd,
        input  idRs, idRt,
        input  memDst, memWe, wbDst, wbWe,
        output fwdA, fwdB, stall
    );

    modport exe (
        output exRs, exRt, exMemRd,
        input  fwdA, fwdB
    );

endinterface

`default_nettype wire

/* rtl/pipeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
    parameter type T = logic
) (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic en_i,
    input  wire logic flush_i,
    input  wire T     d_i,
    output T          q_o
);

    // an all-zero payload is a bubble
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            q_o <= T'('0);
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/decodeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeCtrl import cpuPkg::*; (
    input  wire logic [XLEN-1:0] instr_i,
    output ctrlT                 ctrl_o,
    output logic [XLEN-1:0]      imm_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign imm16  = instr_i[15:0];

    always_comb begin
        ctrl_o = '0;    // anything unknown stays a bubble
        imm_o  = {{(XLEN-16){imm16[15]}}, imm16};
        case (opcode)
            OP_SPECIAL: begin
                ctrl_o.regWe = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    FN_AND:  ctrl_o.aluOp = ALU_AND;
                    FN_OR:   ctrl_o.aluOp = ALU_OR;
                    FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    default: ctrl_o.regWe = 1'b0;   // nop, sll r0 etc
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.regWe  = 1'b1;
                ctrl_o.srcImm = 1'b1;
                ctrl_o.dstRt  = 1'b1;
            end
            OP_LUI: begin
                ctrl_o.aluOp  = ALU_LUI;
                ctrl_o.regWe  = 1'b1;
                ctrl_o.srcImm = 1'b1;
                ctrl_o.dstRt  = 1'b1;
                imm_o         = {imm16, 16'h0000};
            end
            OP_LW: begin
                ctrl_o.regWe  = 1'b1;
                ctrl_o.memRd  = 1'b1;
                ctrl_o.srcImm = 1'b1;
                ctrl_o.dstRt  = 1'b1;
            end
            OP_SW: begin
                ctrl_o.memWr  = 1'b1;
                ctrl_o.srcImm = 1'b1;
            end
            OP_BEQ: begin
                ctrl_o.aluOp    = ALU_SUB;
                ctrl_o.isBranch = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  wire logic            clk_i,
    input  wire logic            rst_i,
    input  wire logic [4:0]      rsAddr_i,
    input  wire logic [4:0]      rtAddr_i,
    input  wire logic [4:0]      wrAddr_i,
    input  wire logic            we_i,
    input  wire logic [XLEN-1:0] wrData_i,
    output logic [XLEN-1:0]      rsData_o,
    output logic [XLEN-1:0]      rtData_o
);

    logic [XLEN-1:0] regs [1:31];   // r0 has no storage

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wrAddr_i != 5'd0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // writeback in the same cycle is seen by decode
    assign rsData_o = (rsAddr_i == 5'd0) ? '0 :
                      (we_i && wrAddr_i == rsAddr_i) ? wrData_i : regs[rsAddr_i];
    assign rtData_o = (rtAddr_i == 5'd0) ? '0 :
                      (we_i && wrAddr_i == rtAddr_i) ? wrData_i : regs[rtAddr_i];

endmodule

`default_nettype wire

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import cpuPkg::*; (
    fwdIf.hazard fwd_o
);

    // nearest older writer wins, r0 never forwards
    function automatic logic [1:0] pickSrc(
        input logic [4:0] src,
        input logic       memWe,
        input logic [4:0] memDst,
        input logic       wbWe,
        input logic [4:0] wbDst
    );
        if (memWe && memDst != 5'd0 && memDst == src) begin
            return FWD_MEM;
        end else if (wbWe && wbDst != 5'd0 && wbDst == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_o.fwdA = pickSrc(fwd_o.exRs, fwd_o.memWe, fwd_o.memDst,
                                fwd_o.wbWe, fwd_o.wbDst);
    assign fwd_o.fwdB = pickSrc(fwd_o.exRt, fwd_o.memWe, fwd_o.memDst,
                                fwd_o.wbWe, fwd_o.wbDst);

    // load in EX feeds the instruction in ID
    assign fwd_o.stall = fwd_o.exMemRd && fwd_o.exRt != 5'd0 &&
                         (fwd_o.exRt == fwd_o.idRs || fwd_o.exRt == fwd_o.idRt);

endmodule

`default_nettype wire

/* rtl/exeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module exeStage import cpuPkg::*; (
    input  wire idExT            idEx_i,
    input  wire logic [XLEN-1:0] memResult_i,
    input  wire logic [XLEN-1:0] wbResult_i,
    fwdIf.exe                    fwd_o,
    output exMemT                exMem_o,
    output logic                 branchTaken_o,
    output logic [XLEN-1:0]      branchTarget_o
);

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] rtFwd;     // forwarded rt, also store data
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluOut;

    function automatic logic [XLEN-1:0] fwdMux(
        input logic [1:0]      sel,
        input logic [XLEN-1:0] regVal,
        input logic [XLEN-1:0] memVal,
        input logic [XLEN-1:0] wbVal
    );
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign fwd_o.exRs    = idEx_i.rs;
    assign fwd_o.exRt    = idEx_i.rt;
    assign fwd_o.exMemRd = idEx_i.ctrl.memRd;

    assign opA   = fwdMux(fwd_o.fwdA, idEx_i.rsVal, memResult_i, wbResult_i);
    assign rtFwd = fwdMux(fwd_o.fwdB, idEx_i.rtVal, memResult_i, wbResult_i);
    assign opB   = idEx_i.ctrl.srcImm ? idEx_i.imm : rtFwd;

    always_comb begin
        case (idEx_i.ctrl.aluOp)
            ALU_SUB: aluOut = opA - opB;
            ALU_AND: aluOut = opA & opB;
            ALU_OR:  aluOut = opA | opB;
            ALU_SLT: aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_LUI: aluOut = opB;  // upper half already placed by decode
            default: aluOut = opA + opB;
        endcase
    end

    assign exMem_o.ctrl      = idEx_i.ctrl;
    assign exMem_o.aluOut    = aluOut;
    assign exMem_o.storeData = rtFwd;
    assign exMem_o.dst       = idEx_i.ctrl.dstRt ? idEx_i.rt : idEx_i.rd;

    assign branchTaken_o  = idEx_i.ctrl.isBranch && (opA == rtFwd);
    assign branchTarget_o = idEx_i.pc + 32'd4 + {idEx_i.imm[XLEN-3:0], 2'b00};

endmodule

`default_nettype wire

/* rtl/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem import cpuPkg::*; (
    input  wire logic            clk_i,
    input  wire logic            rst_i,
    input  wire logic            we_i,
    input  wire logic [XLEN-1:0] addr_i,
    input  wire logic [XLEN-1:0] wrData_i,
    output logic [XLEN-1:0]      rdData_o
);

    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;

    assign idx = addr_i[DMEM_AW+1:2];   // word index, upper bits dropped

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[idx] <= wrData_i;
        end
    end

    assign rdData_o = mem[idx];

endmodule

`default_nettype wire

/* rtl/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore import cpuPkg::*; (
    input  wire logic            clk_i,
    input  wire logic            rst_i,
    output logic [XLEN-1:0]      imemAddr_o,
    input  wire logic [XLEN-1:0] imemData_i,
    output logic                 wbWe_o,
    output logic [4:0]           wbAddr_o,
    output logic [XLEN-1:0]      wbData_o
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcNext;
    ifIdT            ifIdD, ifIdQ;
    idExT            idExD, idExQ;
    exMemT           exMemD, exMemQ;
    memWbT           memWbD, memWbQ;
    ctrlT            idCtrl;
    logic [XLEN-1:0] idImm;
    logic [XLEN-1:0] rsData, rtData;
    logic            branchTaken;
    logic [XLEN-1:0] branchTarget;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] wbResult;

    fwdIf fwdBus ();

    // fetch
    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (fwdBus.stall) begin
            pcNext = pc;    // hold on load-use
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign imemAddr_o  = pc;
    assign ifIdD.pc    = pc;
    assign ifIdD.instr = imemData_i;

    pipeStage #(.T(ifIdT)) uIfId (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .en_i   (!fwdBus.stall),
        .flush_i(branchTaken),
        .d_i    (ifIdD),
        .q_o    (ifIdQ)
    );

    // decode
    decodeCtrl uDecode (
        .instr_i(ifIdQ.instr),
        .ctrl_o (idCtrl),
        .imm_o  (idImm)
    );

    regFile uRegs (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .rsAddr_i(ifIdQ.instr[25:21]),
        .rtAddr_i(ifIdQ.instr[20:16]),
        .wrAddr_i(wbAddr_o),
        .we_i    (wbWe_o),
        .wrData_i(wbResult),
        .rsData_o(rsData),
        .rtData_o(rtData)
    );

    assign idExD.ctrl  = idCtrl;
    assign idExD.pc    = ifIdQ.pc;
    assign idExD.rsVal = rsData;
    assign idExD.rtVal = rtData;
    assign idExD.imm   = idImm;
    assign idExD.rs    = ifIdQ.instr[25:21];
    assign idExD.rt    = ifIdQ.instr[20:16];
    assign idExD.rd    = ifIdQ.instr[15:11];

    pipeStage #(.T(idExT)) uIdEx (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .en_i   (1'b1),
        .flush_i(branchTaken || fwdBus.stall),  // bubble into EX
        .d_i    (idExD),
        .q_o    (idExQ)
    );

    // hazard loop wiring
    assign fwdBus.idRs   = ifIdQ.instr[25:21];
    assign fwdBus.idRt   = ifIdQ.instr[20:16];
    assign fwdBus.memDst = exMemQ.dst;
    assign fwdBus.memWe  = exMemQ.ctrl.regWe;
    assign fwdBus.wbDst  = memWbQ.dst;
    assign fwdBus.wbWe   = memWbQ.regWe;

    hazardUnit uHazard (
        .fwd_o(fwdBus.hazard)
    );

    // execute
    exeStage uExe (
        .idEx_i        (idExQ),
        .memResult_i   (exMemQ.aluOut),
        .wbResult_i    (wbResult),
        .fwd_o         (fwdBus.exe),
        .exMem_o       (exMemD),
        .branchTaken_o (branchTaken),
        .branchTarget_o(branchTarget)
    );

    pipeStage #(.T(exMemT)) uExMem (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .en_i   (1'b1),
        .flush_i(1'b0),
        .d_i    (exMemD),
        .q_o    (exMemQ)
    );

    // memory
    dataMem uDmem (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .we_i    (exMemQ.ctrl.memWr),
        .addr_i  (exMemQ.aluOut),
        .wrData_i(exMemQ.storeData),
        .rdData_o(loadData)
    );

    assign memWbD.regWe    = exMemQ.ctrl.regWe;
    assign memWbD.memRd    = exMemQ.ctrl.memRd;
    assign memWbD.aluOut   = exMemQ.aluOut;
    assign memWbD.loadData = loadData;
    assign memWbD.dst      = exMemQ.dst;

    pipeStage #(.T(memWbT)) uMemWb (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .en_i   (1'b1),
        .flush_i(1'b0),
        .d_i    (memWbD),
        .q_o    (memWbQ)
    );

    // writeback
    assign wbResult = memWbQ.memRd ? memWbQ.loadData : memWbQ.aluOut;
    assign wbWe_o   = memWbQ.regWe && memWbQ.dst != 5'd0;
    assign wbAddr_o = memWbQ.dst;
    assign wbData_o = wbResult;

endmodule

`default_nettype wire

/* dv/mipsCoreSva.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreSva import cpuPkg::*; (
    input wire logic            clk_i,
    input wire logic            rst_i,
    input wire logic [XLEN-1:0] imemAddr_i,
    input wire logic            wbWe_i,
    input wire logic [4:0]      wbAddr_i
);

    // pipeline still filling with bubbles
    emptyAfterReset: assert property (@(posedge clk_i)
        !rst_i && ($past(rst_i, 1) || $past(rst_i, 2) || $past(rst_i, 3) || $past(rst_i, 4))
        |-> !wbWe_i)
        else $error("writeback seen within four cycles of reset release");

    pcAligned: assert property (@(posedge clk_i) disable iff (rst_i)
        imemAddr_i[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    noZeroWrite: assert property (@(posedge clk_i) disable iff (rst_i)
        wbWe_i |-> wbAddr_i != 5'd0)
        else $error("writeback to r0 signalled");

    // only forward branches, so the fetch address never goes back
    pcForward: assert property (@(posedge clk_i) disable iff (rst_i)
        !$past(rst_i) |-> imemAddr_i >= $past(imemAddr_i))
        else $error("fetch address moved backwards");

endmodule

`default_nettype wire

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb import cpuPkg::*; ();

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] imemAddr;
    logic [XLEN-1:0] imemData;
    logic            wbWe;
    logic [4:0]      wbAddr;
    logic [XLEN-1:0] wbData;

    logic [31:0] prog [0:255];
    int          progLen;
    logic [4:0]  expAddr [$];   // expected writebacks in program order
    logic [31:0] expData [$];
    integer      seed;
    int          cycles;
    int          cycleLimit;
    int          testErrors;
    int          testsRun;
    int          passCount;
    int          failCount;

    mipsCore dut_i (
        .clk_i     (clk),
        .rst_i     (rst),
        .imemAddr_o(imemAddr),
        .imemData_i(imemData),
        .wbWe_o    (wbWe),
        .wbAddr_o  (wbAddr),
        .wbData_o  (wbData)
    );

    bind mipsCore mipsCoreSva coreSva (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .imemAddr_i(imemAddr_o),
        .wbWe_i    (wbWe_o),
        .wbAddr_i  (wbAddr_o)
    );

    // past the program end the core sees nops
    assign imemData = (imemAddr < 32'(progLen * 4)) ? prog[imemAddr[9:2]] : 32'h0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout after %0d cycles, a test never finished", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rType(
        input functE      fn,
        input logic [4:0] rd,
        input logic [4:0] rs,
        input logic [4:0] rt
    );
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(
        input opcodeE      op,
        input logic [4:0]  rt,
        input logic [4:0]  rs,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] ins);
        prog[progLen] = ins;
        progLen++;
    endtask

    // sequential ISA model, no delay slot
    task automatic runModel();
        logic [31:0] r [32];
        logic [31:0] m [64];
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        we;
        int          pcIdx;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 64; i++) m[i] = '0;
        expAddr.delete();
        expData.delete();
        pcIdx = 0;
        while (pcIdx < progLen) begin
            ins   = prog[pcIdx];
            a     = r[ins[25:21]];
            b     = r[ins[20:16]];
            imm   = {{16{ins[15]}}, ins[15:0]};
            addr  = a + imm;
            dst   = ins[20:16];
            we    = 1'b0;
            res   = '0;
            pcIdx++;
            case (ins[31:26])
                OP_SPECIAL: begin
                    dst = ins[15:11];
                    we  = 1'b1;
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        default: we = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    we  = 1'b1;
                    res = addr;
                end
                OP_LUI: begin
                    we  = 1'b1;
                    res = {ins[15:0], 16'h0000};
                end
                OP_LW: begin
                    we  = 1'b1;
                    res = m[addr[7:2]];
                end
                OP_SW: m[addr[7:2]] = b;
                OP_BEQ: begin
                    if (a == b) begin
                        pcIdx = pcIdx + int'($signed(ins[15:0]));
                    end
                end
                default: ;
            endcase
            if (we && dst != 5'd0) begin
                r[dst] = res;
                expAddr.push_back(dst);
                expData.push_back(res);
            end
        end
    endtask

    task automatic checkWriteback();
        if (wbWe) begin
            assert (expAddr.size() > 0) else begin
                $display("%0t: writeback to r%0d after all expected writes", $time, wbAddr);
                testErrors++;
            end
            if (expAddr.size() > 0) begin
                assert (wbAddr == expAddr[0]) else begin
                    $display("** Error at %0t: wbAddr_o is %0d, expected %0d",
                             $time, wbAddr, expAddr[0]);
                    testErrors++;
                end
                assert (wbData == expData[0]) else begin
                    $display("** Error at %0t: wbData_o is %h, expected %h",
                             $time, wbData, expData[0]);
                    testErrors++;
                end
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
        end
    endtask

    task automatic startTest();
        @(posedge clk);
        #2;
        rst     = 1'b1;
        progLen = 0;
    endtask

    task automatic finishTest(input string name);
        int stable;
        runModel();
        cycleLimit += 3 * progLen;
        testErrors = 0;
        repeat (5) @(posedge clk);
        #2;
        rst    = 1'b0;
        stable = 0;
        // done once fetch has stayed past the end long enough to drain
        while (stable < 8) begin
            @(negedge clk);
            checkWriteback();
            if (imemAddr >= 32'(progLen * 4)) begin
                stable++;
            end else begin
                stable = 0;
            end
        end
        assert (expAddr.size() == 0) else begin
            $display("%0t: %0d expected writebacks never appeared", $time, expAddr.size());
            testErrors++;
        end
        testsRun++;
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            failCount++;
            $display("test %0d %s: %0d errors", testsRun, name, testErrors);
        end
    endtask

    task automatic testAluChain();
        startTest();
        emit(iType(OP_ADDIU, 5'd1, 5'd0, 16'd5));
        emit(iType(OP_ADDIU, 5'd2, 5'd1, 16'd7));   // rs from MEM
        emit(rType(FN_ADDU, 5'd3, 5'd2, 5'd1));     // MEM and WB sources
        emit(rType(FN_SUBU, 5'd4, 5'd3, 5'd1));
        emit(rType(FN_AND, 5'd5, 5'd4, 5'd3));
        emit(rType(FN_OR, 5'd6, 5'd5, 5'd4));
        emit(rType(FN_SLT, 5'd7, 5'd1, 5'd6));
        emit(rType(FN_SLT, 5'd8, 5'd6, 5'd1));
        emit(rType(FN_SUBU, 5'd9, 5'd1, 5'd2));     // goes negative
        emit(rType(FN_SLT, 5'd10, 5'd9, 5'd1));     // signed compare
        emit(rType(FN_OR, 5'd11, 5'd10, 5'd9));
        emit(rType(FN_ADDU, 5'd11, 5'd11, 5'd11));
        finishTest("alu chain");
    endtask

    task automatic testImmediates();
        startTest();
        emit(iType(OP_LUI, 5'd1, 5'd0, 16'h1234));
        emit(iType(OP_ADDIU, 5'd1, 5'd1, 16'h5678));
        emit(iType(OP_LUI, 5'd2, 5'd0, 16'hdead));
        emit(iType(OP_ADDIU, 5'd2, 5'd2, 16'h7eef));
        emit(iType(OP_ADDIU, 5'd3, 5'd0, 16'hffff)); // -1
        emit(iType(OP_ADDIU, 5'd4, 5'd1, 16'h8000)); // most negative
        emit(iType(OP_LUI, 5'd5, 5'd0, 16'hffff));
        emit(iType(OP_ADDIU, 5'd5, 5'd5, 16'hfffe));
        finishTest("immediates");
    endtask

    task automatic testMemory();
        startTest();
        emit(iType(OP_ADDIU, 5'd1, 5'd0, 16'h0011));
        emit(iType(OP_ADDIU, 5'd2, 5'd0, 16'h0022));
        emit(iType(OP_LUI, 5'd3, 5'd0, 16'habcd));
        emit(iType(OP_ADDIU, 5'd3, 5'd3, 16'h1234));
        emit(iType(OP_SW, 5'd1, 5'd0, 16'd0));
        emit(iType(OP_SW, 5'd2, 5'd0, 16'd4));
        emit(iType(OP_SW, 5'd3, 5'd0, 16'd252));
        emit(iType(OP_ADDIU, 5'd4, 5'd0, 16'd8));
        emit(iType(OP_SW, 5'd3, 5'd4, 16'd0));      // base from MEM
        emit(iType(OP_LW, 5'd5, 5'd0, 16'd0));
        emit(rType(FN_ADDU, 5'd6, 5'd5, 5'd1));     // load-use
        emit(iType(OP_LW, 5'd7, 5'd0, 16'd4));
        emit(iType(OP_SW, 5'd7, 5'd0, 16'd16));     // loaded store data
        emit(iType(OP_LW, 5'd8, 5'd0, 16'd16));
        emit(iType(OP_LW, 5'd9, 5'd0, 16'd252));
        emit(iType(OP_ADDIU, 5'd10, 5'd9, 16'd1));
        emit(iType(OP_LW, 5'd11, 5'd4, 16'd0));
        emit(rType(FN_SUBU, 5'd12, 5'd11, 5'd3));
        emit(iType(OP_LW, 5'd14, 5'd0, 16'd4));
        emit(iType(OP_ADDIU, 5'd15, 5'd0, 16'd3));
        emit(rType(FN_ADDU, 5'd16, 5'd14, 5'd15));  // load from WB
        finishTest("memory and load-use");
    endtask

    task automatic testBranches();
        startTest();
        emit(iType(OP_ADDIU, 5'd1, 5'd0, 16'd7));
        emit(iType(OP_ADDIU, 5'd2, 5'd0, 16'd7));
        emit(iType(OP_BEQ, 5'd2, 5'd1, 16'd2));     // taken, r2 forwarded
        emit(iType(OP_ADDIU, 5'd3, 5'd0, 16'd1));
        emit(iType(OP_ADDIU, 5'd4, 5'd0, 16'd2));
        emit(iType(OP_ADDIU, 5'd5, 5'd0, 16'd3));
        emit(iType(OP_BEQ, 5'd5, 5'd1, 16'd2));     // not taken
        emit(iType(OP_ADDIU, 5'd6, 5'd0, 16'd4));
        emit(iType(OP_ADDIU, 5'd7, 5'd0, 16'd5));
        emit(iType(OP_ADDIU, 5'd8, 5'd1, 16'd0));
        emit(iType(OP_BEQ, 5'd2, 5'd8, 16'd1));
        emit(iType(OP_ADDIU, 5'd9, 5'd0, 16'd6));
        emit(iType(OP_ADDIU, 5'd10, 5'd0, 16'd7));
        emit(iType(OP_LW, 5'd11, 5'd0, 16'd0));
        emit(iType(OP_BEQ, 5'd0, 5'd11, 16'd2));    // stall, then taken
        emit(iType(OP_ADDIU, 5'd12, 5'd0, 16'd8));
        emit(iType(OP_ADDIU, 5'd13, 5'd0, 16'd9));
        emit(iType(OP_ADDIU, 5'd14, 5'd0, 16'd10));
        emit(iType(OP_BEQ, 5'd0, 5'd0, 16'd1));
        emit(iType(OP_ADDIU, 5'd15, 5'd0, 16'd11));
        emit(iType(OP_ADDIU, 5'd16, 5'd0, 16'd12));
        finishTest("branches");
    endtask

    task automatic testRegZero();
        startTest();
        emit(iType(OP_ADDIU, 5'd0, 5'd0, 16'd5));
        emit(rType(FN_ADDU, 5'd1, 5'd0, 5'd0));
        emit(iType(OP_ADDIU, 5'd2, 5'd0, 16'd9));
        emit(rType(FN_OR, 5'd0, 5'd2, 5'd2));
        emit(rType(FN_ADDU, 5'd3, 5'd0, 5'd2));     // r0 must not forward
        emit(iType(OP_LUI, 5'd0, 5'd0, 16'hffff));
        emit(iType(OP_ADDIU, 5'd4, 5'd0, 16'd1));
        emit(iType(OP_SW, 5'd2, 5'd0, 16'd0));
        emit(iType(OP_LW, 5'd0, 5'd0, 16'd0));
        emit(rType(FN_ADDU, 5'd5, 5'd0, 5'd2));
        finishTest("register zero");
    endtask

    task automatic testRandom();
        logic [31:0] rnd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] memOff;
        int          off;
        int          total;
        startTest();
        total = 15 + 200;
        for (int r = 1; r < 16; r++) begin
            rnd = $random(seed);
            emit(iType(OP_ADDIU, 5'(r), 5'd0, rnd[15:0]));
        end
        for (int i = 0; i < 200; i++) begin
            rnd    = $random(seed);
            rs     = {1'b0, rnd[3:0]};
            rt     = {1'b0, rnd[7:4]};
            rd     = {1'b0, rnd[11:8]};
            memOff = {8'h00, rnd[23:18], 2'b00};    // r0 based, inside 64 words
            case (rnd[15:12] % 4'd10)
                4'd0: emit(rType(FN_ADDU, rd, rs, rt));
                4'd1: emit(rType(FN_SUBU, rd, rs, rt));
                4'd2: emit(rType(FN_AND, rd, rs, rt));
                4'd3: emit(rType(FN_OR, rd, rs, rt));
                4'd4: emit(rType(FN_SLT, rd, rs, rt));
                4'd5: emit(iType(OP_ADDIU, rt, rs, rnd[31:16]));
                4'd6: emit(iType(OP_LUI, rt, 5'd0, rnd[31:16]));
                4'd7: emit(iType(OP_LW, rt, 5'd0, memOff));
                4'd8: emit(iType(OP_SW, rt, 5'd0, memOff));
                default: begin
                    // same register often, so some branches are taken
                    if (rnd[16]) begin
                        rt = rs;
                    end
                    off = int'(rnd[26:25]) + 1;
                    if (progLen + 1 + off > total) begin
                        off = total - progLen - 1;
                    end
                    emit(iType(OP_BEQ, rt, rs, 16'(off)));
                end
            endcase
        end
        finishTest("random stream");
    endtask

    initial begin
        rst        = 1'b1;
        progLen    = 0;
        seed       = 32'hfc42_94c5;
        cycles     = 0;
        cycleLimit = 100;
        testErrors = 0;
        testsRun   = 0;
        passCount  = 0;
        failCount  = 0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = 32'h0;
        end
        testAluChain();
        testImmediates();
        testMemory();
        testBranches();
        testRegZero();
        testRandom();
        $display("tests run %0d, passed %0d, failed %0d", testsRun, passCount, failCount);
        if (failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/cpuPkg.sv
rtl/fwdIf.sv
rtl/pipeStage.sv
rtl/decodeCtrl.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/exeStage.sv
rtl/dataMem.sv
rtl/mipsCore.sv
dv/mipsCoreSva.sv
dv/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module mipsCoreTb -o mipsCoreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mipsCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
